// File: files.f
logic/hal_pkg.sv
logic/host_cmd_ctrl.sv
logic/audio_mix.sv
logic/video_window.sv
logic/front_panel.sv
logic/hal_top.sv
tests/tb_hal_top.sv

// File: Bender.yml
package:
  name: hal_core

sources:
  - logic/hal_pkg.sv
  - logic/host_cmd_ctrl.sv
  - logic/audio_mix.sv
  - logic/video_window.sv
  - logic/front_panel.sv
  - logic/hal_top.sv
  - target: test
    files:
      - tests/tb_hal_top.sv

// File: tests/tb_hal_top.sv
`default_nettype none

module tb_hal_top;

	localparam int NUM_ROWS  = 12;
	localparam int TIMEOUT   = NUM_ROWS * 200 + 40000;
	localparam int SETTLE    = 64;
	localparam int BTN_LIMIT = (hal_pkg::DEBOUNCE_LEN + 1) * hal_pkg::DEBOUNCE_TICK + 4;

	logic clk_sys = 1'b0;
	logic resetd;

	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic                wb_adr;
	hal_pkg::host_word_t wb_wdat;
	hal_pkg::host_word_t wb_rdat;
	logic                wb_ack;

	logic                btn_user_raw;
	logic                btn_osd_raw;
	logic                led_user;
	logic [1:0]          led_power;
	logic [1:0]          led_disk;
	logic                pll_locked;
	logic [7:0]          led;
	logic                btn_user;
	logic                btn_osd;

	hal_pkg::aspect_t    arx;
	hal_pkg::aspect_t    ary;
	logic                shrink;
	hal_pkg::dim_t       hmin;
	hal_pkg::dim_t       hmax;
	hal_pkg::dim_t       vmin;
	hal_pkg::dim_t       vmax;

	hal_pkg::sample_t    core_l;
	hal_pkg::sample_t    core_r;
	hal_pkg::sample_t    linux_l;
	hal_pkg::sample_t    linux_r;
	logic                audio_signed;
	hal_pkg::mix_t       audio_mix;
	hal_pkg::sample_t    audio_l;
	hal_pkg::sample_t    audio_r;

	// Register state expected from the commands sent so far
	hal_pkg::dim_t       sh_width;
	hal_pkg::dim_t       sh_height;
	hal_pkg::dim_t       sh_vset;
	hal_pkg::att_t       sh_att;
	logic [7:0]          sh_overtake;
	logic [7:0]          sh_state;

	// Stimulus table
	hal_pkg::cmd_t       tab_cmd    [NUM_ROWS];
	hal_pkg::host_word_t tab_w0     [NUM_ROWS];
	hal_pkg::host_word_t tab_w1     [NUM_ROWS];
	hal_pkg::aspect_t    tab_arx    [NUM_ROWS];
	hal_pkg::aspect_t    tab_ary    [NUM_ROWS];
	logic                tab_shrink [NUM_ROWS];
	hal_pkg::mix_t       tab_mix    [NUM_ROWS];
	logic                tab_sgn    [NUM_ROWS];
	logic                tab_big    [NUM_ROWS];
	logic [5:0]          tab_led    [NUM_ROWS];

	int unsigned cycles = 0;

	hal_top hal_top_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_wb_cyc       (wb_cyc),
		.i_wb_stb       (wb_stb),
		.i_wb_we        (wb_we),
		.i_wb_adr       (wb_adr),
		.i_wb_dat       (wb_wdat),
		.o_wb_dat       (wb_rdat),
		.o_wb_ack       (wb_ack),
		.i_btn_user_raw (btn_user_raw),
		.i_btn_osd_raw  (btn_osd_raw),
		.i_led_user     (led_user),
		.i_led_power    (led_power),
		.i_led_disk     (led_disk),
		.i_pll_locked   (pll_locked),
		.o_led          (led),
		.o_btn_user     (btn_user),
		.o_btn_osd      (btn_osd),
		.i_arx          (arx),
		.i_ary          (ary),
		.i_shrink       (shrink),
		.o_hmin         (hmin),
		.o_hmax         (hmax),
		.o_vmin         (vmin),
		.o_vmax         (vmax),
		.i_core_l       (core_l),
		.i_core_r       (core_r),
		.i_linux_l      (linux_l),
		.i_linux_r      (linux_r),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Something failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Checker and reference model
	////////////////////////////////////////

	task automatic check(input logic [47:0] got, input logic [47:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	function automatic logic [47:0] window_ref(input int w, input int h, input int vs,
		input int ax, input int ay, input logic shr);
		int tw;
		int th;
		int h0;
		int v0;
		if (ax == 0 || ay == 0) begin
			return {12'd0, 12'(w - 1), 12'd0, 12'(h - 1)};
		end
		if (vs != 0) begin
			tw = vs * ax / ay;
			th = vs;
		end else begin
			tw = (h * ax / ay > w) ? w : h * ax / ay;
			th = (w * ay / ax > h) ? h : w * ay / ax;
		end
		if (shr) begin
			tw = tw / 2;
			th = th / 2;
		end
		// Centered in the frame
		h0 = (w - tw) / 2;
		v0 = (h - th) / 2;
		return {12'(h0), 12'(h0 + tw - 1), 12'(v0), 12'(v0 + th - 1)};
	endfunction

	// Core plus linux, unsigned core at half scale
	function automatic int mix_sum(input hal_pkg::sample_t core, input hal_pkg::sample_t lin,
		input logic sgn);
		int c;
		c = sgn ? int'($signed(core)) : int'(core) / 2;
		return c + int'($signed(lin));
	endfunction

	function automatic hal_pkg::sample_t audio_ref(input int own, input int other,
		input hal_pkg::mix_t mix, input hal_pkg::att_t att);
		int m;
		case (mix)
			2'd0: m = own;
			// Own channel loses what the other one gives
			2'd1: m = own - (own >>> 3) + (other >>> 3);
			2'd2: m = own - (own >>> 2) + (other >>> 2);
			default: m = (own >>> 1) + (other >>> 1);
		endcase
		if (att[4]) begin
			m = 0;
		end else begin
			m = m >>> att[3:0];
		end
		if (m > 32767) begin
			m = 32767;
		end
		if (m < -32768) begin
			m = -32768;
		end
		return 16'(m);
	endfunction

	function automatic logic [7:0] led_ref(input logic [7:0] ot, input logic [7:0] st,
		input logic [5:0] ins);
		logic       usr;
		logic [1:0] pwr_in;
		logic [1:0] dsk_in;
		logic       locked;
		logic       pwr;
		logic       dsk;
		logic [7:0] pattern;
		{locked, dsk_in, pwr_in, usr} = ins;
		pwr = pwr_in[1] ? ~pwr_in[0] : 1'b0;
		dsk = ~dsk_in[0];
		pattern = {1'b0, locked, 1'b0, ~pwr, 1'b0, ~dsk, 1'b0, usr};
		return (ot & st) | (~ot & pattern);
	endfunction

	function automatic hal_pkg::host_word_t status_word(input logic user, input logic osd);
		return {user, osd, 4'd0, hal_pkg::IO_VERSION, 8'd0};
	endfunction

	////////////////////////////////////////
	// Wishbone host
	////////////////////////////////////////

	task automatic wb_write(input logic adr, input hal_pkg::host_word_t dat);
		@(posedge clk_sys);
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		wb_we   <= 1'b1;
		wb_adr  <= adr;
		wb_wdat <= dat;
		do begin
			@(posedge clk_sys);
		end while (!wb_ack);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic adr, output hal_pkg::host_word_t dat);
		@(posedge clk_sys);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		do begin
			@(posedge clk_sys);
		end while (!wb_ack);
		dat = wb_rdat;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic send_cmd(input hal_pkg::cmd_t cmd, input hal_pkg::host_word_t w0,
		input hal_pkg::host_word_t w1);
		hal_pkg::host_word_t word;
		wb_write(hal_pkg::ADR_CMD, {8'h00, cmd});
		if (cmd == hal_pkg::CMD_TIMING) begin
			// Enough extra words that a wrapping counter would reach 0 and 4 again
			for (int i = 0; i < 22; i++) begin
				word = 16'($urandom);
				if (i == 0) begin
					word = w0;
				end
				if (i == 4) begin
					word = w1;
				end
				wb_write(hal_pkg::ADR_DATA, word);
			end
		end else begin
			wb_write(hal_pkg::ADR_DATA, w0);
		end
		case (cmd)
			hal_pkg::CMD_TIMING: begin
				sh_width  = w0[11:0];
				sh_height = w1[11:0];
			end
			hal_pkg::CMD_LED: begin
				sh_overtake = w0[15:8];
				sh_state    = w0[7:0];
			end
			hal_pkg::CMD_VOLUME: sh_att = w0[4:0];
			hal_pkg::CMD_VSET:   sh_vset = w0[11:0];
			default: ;
		endcase
	endtask

	////////////////////////////////////////
	// Table rows
	////////////////////////////////////////

	task automatic set_row(input int r, input hal_pkg::cmd_t cmd, input hal_pkg::host_word_t w0,
		input hal_pkg::host_word_t w1, input hal_pkg::aspect_t ax, input hal_pkg::aspect_t ay,
		input logic shr, input hal_pkg::mix_t mix, input logic sgn, input logic big,
		input logic [5:0] ledin);
		tab_cmd[r]    = cmd;
		tab_w0[r]     = w0;
		tab_w1[r]     = w1;
		tab_arx[r]    = ax;
		tab_ary[r]    = ay;
		tab_shrink[r] = shr;
		tab_mix[r]    = mix;
		tab_sgn[r]    = sgn;
		tab_big[r]    = big;
		tab_led[r]    = ledin;
	endtask

	task automatic fill_table();
		// Row, cmd, w0, w1, arx, ary, shrink, mix, signed, full scale, {locked,disk,power,user}
		set_row(0, 8'h31, 16'hffff, 16'h0000, 8'd0, 8'd0, 1'b0, 2'd0, 1'b1, 1'b0, 6'b1_00_00_0);
		set_row(1, hal_pkg::CMD_TIMING, 16'hf500, 16'ha2d0, 8'd4, 8'd3, 1'b0, 2'd0, 1'b1, 1'b0,
			6'b1_10_11_1);
		set_row(2, hal_pkg::CMD_VOLUME, 16'h0000, 16'h0, 8'd16, 8'd9, 1'b0, 2'd1, 1'b1, 1'b0,
			6'b0_11_10_0);
		set_row(3, hal_pkg::CMD_VSET, 16'h0258, 16'h0, 8'd4, 8'd3, 1'b0, 2'd2, 1'b0, 1'b0,
			6'b1_01_01_1);
		set_row(4, hal_pkg::CMD_VSET, 16'h0000, 16'h0, 8'd4, 8'd3, 1'b1, 2'd3, 1'b1, 1'b0,
			6'b0_00_11_0);
		set_row(5, hal_pkg::CMD_VOLUME, 16'h0003, 16'h0, 8'd0, 8'd0, 1'b0, 2'd3, 1'b0, 1'b0,
			6'b1_10_00_1);
		set_row(6, hal_pkg::CMD_VOLUME, 16'h0010, 16'h0, 8'd4, 8'd3, 1'b0, 2'd1, 1'b1, 1'b0,
			6'b0_01_10_1);
		set_row(7, hal_pkg::CMD_VOLUME, 16'h0000, 16'h0, 8'd16, 8'd9, 1'b1, 2'd0, 1'b1, 1'b1,
			6'b1_11_11_0);
		set_row(8, hal_pkg::CMD_LED, 16'ha53c, 16'h0, 8'd0, 8'd0, 1'b0, 2'd0, 1'b0, 1'b0,
			6'b1_01_10_0);
		set_row(9, 8'h3b, 16'h1234, 16'h0, 8'd0, 8'd0, 1'b0, 2'd1, 1'b0, 1'b0, 6'b0_10_11_1);
		set_row(10, hal_pkg::CMD_LED, 16'h0ff0, 16'h0, 8'd4, 8'd3, 1'b0, 2'd2, 1'b1, 1'b0,
			6'b1_11_01_0);
		set_row(11, hal_pkg::CMD_VSET, 16'hf1e0, 16'h0, 8'd16, 8'd9, 1'b0, 2'd2, 1'b1, 1'b0,
			6'b0_00_00_1);
	endtask

	task automatic apply_row(input int r);
		hal_pkg::sample_t cl;
		hal_pkg::sample_t cr;
		hal_pkg::sample_t ll;
		hal_pkg::sample_t lr;
		int               sum_l;
		int               sum_r;
		if (tab_big[r]) begin
			// Full scale, positive left and negative right
			cl = 16'h7fff;
			ll = 16'h7fff;
			cr = 16'h8000;
			lr = 16'h8000;
		end else begin
			cl = 16'($urandom);
			ll = 16'($urandom);
			cr = 16'($urandom);
			lr = 16'($urandom);
		end
		@(posedge clk_sys);
		arx          <= tab_arx[r];
		ary          <= tab_ary[r];
		shrink       <= tab_shrink[r];
		audio_mix    <= tab_mix[r];
		audio_signed <= tab_sgn[r];
		core_l       <= cl;
		core_r       <= cr;
		linux_l      <= ll;
		linux_r      <= lr;
		{pll_locked, led_disk, led_power, led_user} <= tab_led[r];
		send_cmd(tab_cmd[r], tab_w0[r], tab_w1[r]);
		repeat (SETTLE) @(posedge clk_sys);
		@(negedge clk_sys);
		sum_l = mix_sum(cl, ll, tab_sgn[r]);
		sum_r = mix_sum(cr, lr, tab_sgn[r]);
		check({hmin, hmax, vmin, vmax},
			window_ref(sh_width, sh_height, sh_vset, tab_arx[r], tab_ary[r], tab_shrink[r]),
			$sformatf("window in row %0d", r));
		check(48'(audio_l), 48'(audio_ref(sum_l, sum_r, tab_mix[r], sh_att)),
			$sformatf("left audio in row %0d", r));
		check(48'(audio_r), 48'(audio_ref(sum_r, sum_l, tab_mix[r], sh_att)),
			$sformatf("right audio in row %0d", r));
		check(48'(led), 48'(led_ref(sh_overtake, sh_state, tab_led[r])),
			$sformatf("LEDs in row %0d", r));
	endtask

	////////////////////////////////////////
	// Buttons
	////////////////////////////////////////

	task automatic wait_buttons(input logic [1:0] want);
		int n;
		n = 0;
		while ({btn_osd, btn_user} != want && n <= BTN_LIMIT) begin
			@(posedge clk_sys);
			n++;
		end
		check(48'({btn_osd, btn_user}), 48'(want), "debounced buttons {osd, user}");
	endtask

	task automatic button_test();
		hal_pkg::host_word_t st;
		@(posedge clk_sys);
		btn_user_raw <= 1'b1;
		btn_osd_raw  <= 1'b1;
		wait_buttons(2'b11);
		wb_read(hal_pkg::ADR_CMD, st);
		check(48'(st), 48'(status_word(1'b1, 1'b1)), "status with both buttons held");
		btn_user_raw <= 1'b0;
		wait_buttons(2'b10);
		wb_read(hal_pkg::ADR_CMD, st);
		check(48'(st), 48'(status_word(1'b0, 1'b1)), "status with OSD button held");
		btn_osd_raw <= 1'b0;
		wait_buttons(2'b00);
		// Pulse shorter than one tick, laid over the next button sample
		repeat (hal_pkg::DEBOUNCE_TICK / 2) @(posedge clk_sys);
		btn_user_raw <= 1'b1;
		repeat (hal_pkg::DEBOUNCE_TICK * 7 / 10) @(posedge clk_sys);
		btn_user_raw <= 1'b0;
		for (int i = 0; i < BTN_LIMIT; i++) begin
			@(negedge clk_sys);
			check(48'(btn_user), 48'(0), "user button after a glitch");
		end
		wb_read(hal_pkg::ADR_CMD, st);
		check(48'(st), 48'(status_word(1'b0, 1'b0)), "status after a glitch");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int unsigned         seed;
		hal_pkg::host_word_t st;
		seed = $urandom(32'hefec);
		resetd       = 1'b1;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = 1'b0;
		wb_wdat      = '0;
		btn_user_raw = 1'b0;
		btn_osd_raw  = 1'b0;
		led_user     = 1'b0;
		led_power    = '0;
		led_disk     = '0;
		pll_locked   = 1'b0;
		arx          = '0;
		ary          = '0;
		shrink       = 1'b0;
		core_l       = '0;
		core_r       = '0;
		linux_l      = '0;
		linux_r      = '0;
		audio_signed = 1'b0;
		audio_mix    = '0;
		sh_width     = hal_pkg::DEFAULT_WIDTH;
		sh_height    = hal_pkg::DEFAULT_HEIGHT;
		sh_vset      = '0;
		sh_att       = '0;
		sh_overtake  = '0;
		sh_state     = '0;
		fill_table();

		repeat (5) @(posedge clk_sys);
		resetd <= 1'b0;

		// Power-on state
		repeat (SETTLE) @(posedge clk_sys);
		@(negedge clk_sys);
		check(48'(wb_ack), 48'(0), "ack after reset");
		check({hmin, hmax, vmin, vmax}, {12'd0, 12'd1919, 12'd0, 12'd1079}, "reset window");
		check(48'(audio_l), 48'(0), "left audio after reset");
		check(48'(audio_r), 48'(0), "right audio after reset");
		check(48'({btn_osd, btn_user}), 48'(0), "buttons after reset");
		wb_read(hal_pkg::ADR_CMD, st);
		check(48'(st), 48'(status_word(1'b0, 1'b0)), "status after reset");
		wb_read(hal_pkg::ADR_DATA, st);
		check(48'(st), 48'(0), "data port read after reset");

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
		end

		button_test();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/hal_top.sv
`default_nettype none

module hal_top (
	input  wire                      clk_sys,
	input  wire                      resetd,

	// Host port
	input  wire                      i_wb_cyc,
	input  wire                      i_wb_stb,
	input  wire                      i_wb_we,
	input  wire                      i_wb_adr,
	input  wire hal_pkg::host_word_t i_wb_dat,
	output wire hal_pkg::host_word_t o_wb_dat,
	output wire                      o_wb_ack,

	// Front panel
	input  wire                      i_btn_user_raw,
	input  wire                      i_btn_osd_raw,
	input  wire                      i_led_user,
	input  wire [1:0]                i_led_power,
	input  wire [1:0]                i_led_disk,
	input  wire                      i_pll_locked,
	output wire [7:0]                o_led,
	output wire                      o_btn_user,
	output wire                      o_btn_osd,

	// Video window
	input  wire hal_pkg::aspect_t    i_arx,
	input  wire hal_pkg::aspect_t    i_ary,
	input  wire                      i_shrink,
	output wire hal_pkg::dim_t       o_hmin,
	output wire hal_pkg::dim_t       o_hmax,
	output wire hal_pkg::dim_t       o_vmin,
	output wire hal_pkg::dim_t       o_vmax,

	// Audio
	input  wire hal_pkg::sample_t    i_core_l,
	input  wire hal_pkg::sample_t    i_core_r,
	input  wire hal_pkg::sample_t    i_linux_l,
	input  wire hal_pkg::sample_t    i_linux_r,
	input  wire                      i_audio_signed,
	input  wire hal_pkg::mix_t       i_audio_mix,
	output wire hal_pkg::sample_t    o_audio_l,
	output wire hal_pkg::sample_t    o_audio_r
);

	wire hal_pkg::dim_t    width;
	wire hal_pkg::dim_t    height;
	wire hal_pkg::dim_t    vset;
	wire hal_pkg::att_t    att;
	wire [7:0]             led_overtake;
	wire [7:0]             led_state;
	wire hal_pkg::sample_t pre_l;
	wire hal_pkg::sample_t pre_r;

	host_cmd_ctrl host_cmd_ctrl_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_wb_cyc       (i_wb_cyc),
		.i_wb_stb       (i_wb_stb),
		.i_wb_we        (i_wb_we),
		.i_wb_adr       (i_wb_adr),
		.i_wb_dat       (i_wb_dat),
		.o_wb_dat       (o_wb_dat),
		.o_wb_ack       (o_wb_ack),
		.i_btn_user     (o_btn_user),
		.i_btn_osd      (o_btn_osd),
		.o_width        (width),
		.o_height       (height),
		.o_vset         (vset),
		.o_att          (att),
		.o_led_overtake (led_overtake),
		.o_led_state    (led_state)
	);

	////////////////////////////////////////
	// Audio, left and right crossfeed each other
	////////////////////////////////////////

	audio_mix audio_mix_l (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_att     (att),
		.i_mix     (i_audio_mix),
		.i_signed  (i_audio_signed),
		.i_core    (i_core_l),
		.i_linux   (i_linux_l),
		.i_pre_in  (pre_r),
		.o_pre_out (pre_l),
		.o_out     (o_audio_l)
	);

	audio_mix audio_mix_r (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_att     (att),
		.i_mix     (i_audio_mix),
		.i_signed  (i_audio_signed),
		.i_core    (i_core_r),
		.i_linux   (i_linux_r),
		.i_pre_in  (pre_l),
		.o_pre_out (pre_r),
		.o_out     (o_audio_r)
	);

	video_window video_window_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_width  (width),
		.i_height (height),
		.i_vset   (vset),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.i_shrink (i_shrink),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

	front_panel front_panel_i (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_btn_user_raw (i_btn_user_raw),
		.i_btn_osd_raw  (i_btn_osd_raw),
		.i_led_overtake (led_overtake),
		.i_led_state    (led_state),
		.i_led_user     (i_led_user),
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_pll_locked   (i_pll_locked),
		.o_btn_user     (o_btn_user),
		.o_btn_osd      (o_btn_osd),
		.o_led          (o_led)
	);

endmodule

`default_nettype wire

// File: logic/front_panel.sv
`default_nettype none

module front_panel (
	input  wire        clk_sys,
	input  wire        resetd,

	input  wire        i_btn_user_raw,
	input  wire        i_btn_osd_raw,

	input  wire [7:0]  i_led_overtake,
	input  wire [7:0]  i_led_state,
	input  wire        i_led_user,
	input  wire [1:0]  i_led_power,
	input  wire [1:0]  i_led_disk,
	input  wire        i_pll_locked,

	output logic       o_btn_user,
	output logic       o_btn_osd,
	output logic [7:0] o_led
);

	logic [$clog2(hal_pkg::DEBOUNCE_TICK)-1:0] tick_cnt;
	logic                                      tick;
	logic [1:0]                                raw_s1;
	logic [1:0]                                raw_s2;
	logic [1:0][hal_pkg::DEBOUNCE_LEN-1:0]     hist;
	logic [1:0][hal_pkg::DEBOUNCE_LEN-1:0]     hist_next;
	logic [1:0]                                btn;
	logic                                      led_p;
	logic                                      led_d;
	logic                                      led_u;
	logic [7:0]                                status;

	////////////////////////////////////////
	// Buttons, index 0 user and 1 OSD
	////////////////////////////////////////

	assign tick = (32'(tick_cnt) == hal_pkg::DEBOUNCE_TICK - 1);

	always_comb begin
		for (int b = 0; b < 2; b++) begin
			hist_next[b] = {hist[b][hal_pkg::DEBOUNCE_LEN-2:0], raw_s2[b]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			tick_cnt <= '0;
			raw_s1   <= '0;
			raw_s2   <= '0;
			hist     <= '0;
			btn      <= '0;
		end else begin
			raw_s1   <= {i_btn_osd_raw, i_btn_user_raw};
			raw_s2   <= raw_s1;
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (tick) begin
				hist <= hist_next;
				for (int b = 0; b < 2; b++) begin
					// Change only on a full run of equal samples
					if (&hist_next[b]) begin
						btn[b] <= 1'b1;
					end
					if (~|hist_next[b]) begin
						btn[b] <= 1'b0;
					end
				end
			end
		end
	end

	assign o_btn_user = btn[0];
	assign o_btn_osd  = btn[1];

	////////////////////////////////////////
	// LEDs
	////////////////////////////////////////

	assign led_p = i_led_power[1] ? ~i_led_power[0] : 1'b0;
	// Disk follows bit 0 in both modes
	assign led_d = ~i_led_disk[0];
	assign led_u = ~i_led_user;

	assign status = {1'b0, i_pll_locked, 1'b0, ~led_p, 1'b0, ~led_d, 1'b0, ~led_u};

	// Host overtake per bit
	assign o_led = (i_led_overtake & i_led_state) | (~i_led_overtake & status);

endmodule

`default_nettype wire

// File: logic/video_window.sv
`default_nettype none

module video_window (
	input  wire                   clk_sys,
	input  wire                   resetd,

	input  wire hal_pkg::dim_t    i_width,
	input  wire hal_pkg::dim_t    i_height,
	input  wire hal_pkg::dim_t    i_vset,
	input  wire hal_pkg::aspect_t i_arx,
	input  wire hal_pkg::aspect_t i_ary,
	input  wire                   i_shrink,

	output hal_pkg::dim_t         o_hmin,
	output hal_pkg::dim_t         o_hmax,
	output hal_pkg::dim_t         o_vmin,
	output hal_pkg::dim_t         o_vmax
);

	hal_pkg::win_state_t state;
	logic [2:0]          wait_cnt;

	hal_pkg::dim_t       wid_q;
	hal_pkg::dim_t       hgt_q;
	hal_pkg::dim_t       vset_q;
	hal_pkg::aspect_t    arx_q;
	hal_pkg::aspect_t    ary_q;
	logic                shrink_q;

	logic [19:0]         w_num;
	logic [19:0]         h_num;
	logic [19:0]         w_quot;
	logic [19:0]         h_quot;
	hal_pkg::dim_t       tgt_w;
	hal_pkg::dim_t       tgt_h;
	hal_pkg::dim_t       videow;
	hal_pkg::dim_t       videoh;
	hal_pkg::dim_t       hofs;
	hal_pkg::dim_t       vofs;

	// Dividers get WIN_CALC_WAIT cycles to settle
	assign w_quot = w_num / ary_q;
	assign h_quot = h_num / arx_q;

	always_comb begin
		tgt_w = w_quot[11:0];
		if (vset_q == '0 && w_quot > {8'd0, wid_q}) begin
			tgt_w = wid_q;
		end
		tgt_h = vset_q;
		if (vset_q == '0) begin
			tgt_h = (h_quot > {8'd0, hgt_q}) ? hgt_q : h_quot[11:0];
		end
	end

	assign hofs = (wid_q - videow) >> 1;
	assign vofs = (hgt_q - videoh) >> 1;

	// Operand snapshot and intermediate results
	always_ff @(posedge clk_sys) begin
		if (state == hal_pkg::WIN_IDLE) begin
			wid_q    <= i_width;
			hgt_q    <= i_height;
			vset_q   <= i_vset;
			arx_q    <= i_arx;
			ary_q    <= i_ary;
			shrink_q <= i_shrink;
		end
		if (state == hal_pkg::WIN_CALC) begin
			w_num <= ((vset_q != '0) ? vset_q : hgt_q) * arx_q;
			h_num <= wid_q * ary_q;
		end
		if (state == hal_pkg::WIN_CLAMP) begin
			videow <= shrink_q ? (tgt_w >> 1) : tgt_w;
			videoh <= shrink_q ? (tgt_h >> 1) : tgt_h;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= hal_pkg::WIN_IDLE;
			wait_cnt <= '0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			case (state)
				hal_pkg::WIN_IDLE: begin
					if (i_arx == '0 || i_ary == '0) begin
						// Full frame
						o_hmin <= '0;
						o_hmax <= i_width - 1'b1;
						o_vmin <= '0;
						o_vmax <= i_height - 1'b1;
					end else begin
						state <= hal_pkg::WIN_CALC;
					end
				end
				hal_pkg::WIN_CALC: begin
					wait_cnt <= '0;
					state    <= hal_pkg::WIN_WAIT;
				end
				hal_pkg::WIN_WAIT: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == 3'(hal_pkg::WIN_CALC_WAIT - 1)) begin
						state <= hal_pkg::WIN_CLAMP;
					end
				end
				hal_pkg::WIN_CLAMP: state <= hal_pkg::WIN_PLACE;
				hal_pkg::WIN_PLACE: begin
					// Center the target
					o_hmin <= hofs;
					o_hmax <= hofs + videow - 1'b1;
					o_vmin <= vofs;
					o_vmax <= vofs + videoh - 1'b1;
					state  <= hal_pkg::WIN_IDLE;
				end
				default: state <= hal_pkg::WIN_IDLE;
			endcase
		end
	end

	a_window_ordered: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(state == hal_pkg::WIN_IDLE) |-> (o_hmin <= o_hmax && o_vmin <= o_vmax)
	);

endmodule

`default_nettype wire

// File: logic/audio_mix.sv
`default_nettype none

module audio_mix (
	input  wire                   clk_sys,
	input  wire                   resetd,

	input  wire hal_pkg::att_t    i_att,
	input  wire hal_pkg::mix_t    i_mix,
	input  wire                   i_signed,

	input  wire hal_pkg::sample_t i_core,
	input  wire hal_pkg::sample_t i_linux,
	input  wire hal_pkg::sample_t i_pre_in,

	output hal_pkg::sample_t      o_pre_out,
	output hal_pkg::sample_t      o_out
);

	hal_pkg::sample_t      core_d1;
	hal_pkg::sample_t      core_d2;
	hal_pkg::sample_t      core_ok;
	hal_pkg::wide_sample_t core_ext;
	hal_pkg::wide_sample_t sum;
	hal_pkg::wide_sample_t mixed;
	hal_pkg::wide_sample_t atten;

	// Unsigned samples are halved so they fit as positive values
	assign core_ext = i_signed ? {core_ok[15], core_ok} : {2'b00, core_ok[15:1]};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_d1   <= '0;
			core_d2   <= '0;
			core_ok   <= '0;
			sum       <= '0;
			mixed     <= '0;
			atten     <= '0;
			o_pre_out <= '0;
			o_out     <= '0;
		end else begin
			// Deglitch
			core_d1 <= i_core;
			core_d2 <= core_d1;
			if (core_d1 == core_d2) begin
				core_ok <= core_d1;
			end

			// Core plus linux
			sum       <= core_ext + {i_linux[15], i_linux};
			o_pre_out <= sum[16:1];

			// Crossfeed, other channel arrives at half scale on i_pre_in
			case (i_mix)
				2'd0: mixed <= sum;
				2'd1: mixed <= sum - {{3{sum[16]}}, sum[16:3]}
					+ {{3{i_pre_in[15]}}, i_pre_in[15:2]};
				2'd2: mixed <= sum - {{2{sum[16]}}, sum[16:2]}
					+ {{2{i_pre_in[15]}}, i_pre_in[15:1]};
				default: mixed <= {sum[16], sum[16:1]} + {i_pre_in[15], i_pre_in};
			endcase

			// Volume
			if (i_att[4]) begin
				atten <= '0;
			end else begin
				atten <= $signed(mixed) >>> i_att[3:0];
			end

			// Saturate back to 16 bits
			if (atten[16] ^ atten[15]) begin
				o_out <= {atten[16], {15{~atten[16]}}};
			end else begin
				o_out <= atten[15:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/host_cmd_ctrl.sv
`default_nettype none

module host_cmd_ctrl (
	input  wire                      clk_sys,
	input  wire                      resetd,

	input  wire                      i_wb_cyc,
	input  wire                      i_wb_stb,
	input  wire                      i_wb_we,
	input  wire                      i_wb_adr,
	input  wire hal_pkg::host_word_t i_wb_dat,
	output hal_pkg::host_word_t      o_wb_dat,
	output logic                     o_wb_ack,

	input  wire                      i_btn_user,
	input  wire                      i_btn_osd,

	output hal_pkg::dim_t            o_width,
	output hal_pkg::dim_t            o_height,
	output hal_pkg::dim_t            o_vset,
	output hal_pkg::att_t            o_att,
	output logic [7:0]               o_led_overtake,
	output logic [7:0]               o_led_state
);

	logic                wb_req;
	logic                wr_cmd;
	logic                wr_data;
	hal_pkg::cmd_t       cmd;
	logic [3:0]          word_cnt;
	hal_pkg::host_word_t status;

	// New request when the bus is asserted and not yet acknowledged
	assign wb_req  = i_wb_cyc & i_wb_stb & ~o_wb_ack;
	assign wr_cmd  = wb_req & i_wb_we & (i_wb_adr == hal_pkg::ADR_CMD);
	assign wr_data = wb_req & i_wb_we & (i_wb_adr == hal_pkg::ADR_DATA);

	assign status = {i_btn_user, i_btn_osd, 4'd0, hal_pkg::IO_VERSION, 8'd0};

	////////////////////////////////////////
	// Wishbone handshake
	////////////////////////////////////////

	// Single-cycle ack
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= wb_req;
		end
	end

	// Read data goes out together with ack
	always_ff @(posedge clk_sys) begin
		if (wb_req && !i_wb_we) begin
			if (i_wb_adr == hal_pkg::ADR_CMD) begin
				o_wb_dat <= status;
			end else begin
				o_wb_dat <= '0;
			end
		end
	end

	////////////////////////////////////////
	// Command byte and word counter
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cmd      <= '0;
			word_cnt <= '0;
		end else if (wr_cmd) begin
			cmd      <= i_wb_dat[7:0];
			word_cnt <= '0;
		end else if (wr_data && word_cnt != 4'd8) begin
			// Stops at 8 so trailing words fall through
			word_cnt <= word_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Host-set registers
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_width        <= hal_pkg::DEFAULT_WIDTH;
			o_height       <= hal_pkg::DEFAULT_HEIGHT;
			o_vset         <= '0;
			o_att          <= '0;
			o_led_overtake <= '0;
			o_led_state    <= '0;
		end else if (wr_data) begin
			case (cmd)
				hal_pkg::CMD_TIMING: begin
					// Only active width and height are kept
					if (word_cnt == 4'd0) begin
						o_width <= i_wb_dat[11:0];
					end
					if (word_cnt == 4'd4) begin
						o_height <= i_wb_dat[11:0];
					end
				end
				hal_pkg::CMD_LED: begin
					o_led_overtake <= i_wb_dat[15:8];
					o_led_state    <= i_wb_dat[7:0];
				end
				hal_pkg::CMD_VOLUME: o_att <= i_wb_dat[4:0];
				hal_pkg::CMD_VSET:   o_vset <= i_wb_dat[11:0];
				default: ;
			endcase
		end
	end

	// Host keeps the request up until it is acknowledged
	a_req_held: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(i_wb_cyc && i_wb_stb && !o_wb_ack) |=> (i_wb_cyc && i_wb_stb)
	);

endmodule

`default_nettype wire

// File: logic/hal_pkg.sv
`default_nettype none

package hal_pkg;

	////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////

	typedef logic [11:0] dim_t;
	typedef logic [15:0] sample_t;
	typedef logic [16:0] wide_sample_t;
	typedef logic [15:0] host_word_t;
	typedef logic [7:0]  cmd_t;
	typedef logic [7:0]  aspect_t;
	// Bit 4 mutes, bits 3:0 are the right shift
	typedef logic [4:0]  att_t;
	typedef logic [1:0]  mix_t;

	typedef enum logic [2:0] {
		WIN_IDLE,
		WIN_CALC,
		WIN_WAIT,
		WIN_CLAMP,
		WIN_PLACE
	} win_state_t;

	////////////////////////////////////////
	// Host commands and addresses
	////////////////////////////////////////

	localparam cmd_t CMD_TIMING = 8'h20;
	localparam cmd_t CMD_LED    = 8'h25;
	localparam cmd_t CMD_VOLUME = 8'h26;
	localparam cmd_t CMD_VSET   = 8'h27;

	localparam logic ADR_CMD  = 1'b0;
	localparam logic ADR_DATA = 1'b1;

	localparam logic [1:0] IO_VERSION = 2'd1;

	// Power-on video timing
	localparam dim_t DEFAULT_WIDTH  = 12'd1920;
	localparam dim_t DEFAULT_HEIGHT = 12'd1080;

	// Front panel and window timing
	localparam int DEBOUNCE_TICK = 1000;
	localparam int DEBOUNCE_LEN  = 8;
	localparam int WIN_CALC_WAIT = 5;

endpackage

`default_nettype wire
